// ==== Bender.yml ====
package:
  name: framebuffer

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/framebuffer_pkg.sv
      - rtl/pixel_stacker.sv
      - rtl/chunk_memory.sv
      - rtl/zoom_counter.sv
      - rtl/unstacker.sv
      - rtl/framebuffer.sv
      - target: test
        include_dirs:
          - rtl
        files:
          - verification/framebuffer_tb.sv

// ==== framebuffer.f ====
+incdir+rtl
rtl/framebuffer_pkg.sv
rtl/pixel_stacker.sv
rtl/chunk_memory.sv
rtl/zoom_counter.sv
rtl/unstacker.sv
rtl/framebuffer.sv
verification/framebuffer_tb.sv

// ==== rtl/chunk_memory.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "framebuffer_consts.svh"

module chunk_memory (
  input wire clk_in,
  input wire reset,
  // write port, always accepted
  input wire wr_en,
  input wire framebuffer_pkg::chunk_addr_t wr_addr,
  input wire framebuffer_pkg::chunk_data_t wr_data,
  input wire framebuffer_pkg::chunk_strb_t wr_strb,
  // read request
  input wire rd_addr_valid,
  output logic rd_addr_ready,
  input wire framebuffer_pkg::chunk_addr_t rd_addr,
  input wire rd_last_in,
  // read response
  output logic chunk_tvalid,
  input wire chunk_tready,
  output framebuffer_pkg::chunk_data_t chunk_tdata,
  output logic chunk_tlast
);
  import framebuffer_pkg::*;

  localparam int STRB_W = $bits(chunk_strb_t);

  chunk_data_t mem [`FB_CHUNK_DEPTH];
  logic rd_fire;

  // writes win the port, and a full slot must drain first
  assign rd_addr_ready = !wr_en && (!chunk_tvalid || chunk_tready);
  assign rd_fire = rd_addr_valid && rd_addr_ready;

  // per-byte enables keep unstrobed bytes
  always_ff @(posedge clk_in) begin
    if (wr_en) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_strb[b]) begin
          mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

  // output slot valid
  always_ff @(posedge clk_in) begin
    if (reset) begin
      chunk_tvalid <= 1'b0;
    end else if (rd_fire) begin
      chunk_tvalid <= 1'b1;
    end else if (chunk_tready) begin
      chunk_tvalid <= 1'b0;
    end
  end

  // data and frame flag travel together
  always_ff @(posedge clk_in) begin
    if (rd_fire) begin
      chunk_tdata <= mem[rd_addr];
      chunk_tlast <= rd_last_in;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/framebuffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "framebuffer_consts.svh"

module framebuffer #(
  parameter int SCALE_FACTOR = `FB_SCALE
) (
  input wire clk_in,
  input wire reset,
  // in from rasterizer
  input wire valid_in,
  input wire framebuffer_pkg::pixel_addr_t addr_in,
  input wire framebuffer_pkg::pixel_t color_in,
  input wire flush,
  // scanout side
  input wire scan_enable,
  output logic frame_buff_tvalid,
  input wire frame_buff_tready,
  output framebuffer_pkg::pixel_t frame_buff_tdata,
  output logic frame_buff_tlast
);
  import framebuffer_pkg::*;

  // stacker to memory
  logic wr_en;
  chunk_addr_t wr_addr;
  chunk_data_t wr_data;
  chunk_strb_t wr_strb;

  // scan requests
  logic rd_addr_valid;
  logic rd_addr_ready;
  chunk_addr_t rd_addr;
  logic rd_last_in;

  // memory to unstacker
  logic chunk_tvalid;
  logic chunk_tready;
  chunk_data_t chunk_tdata;
  logic chunk_tlast;

  assign rd_addr_valid = scan_enable;

  pixel_stacker stacker_inst (
    .clk_in(clk_in),
    .reset(reset),
    .valid_in(valid_in),
    .addr_in(addr_in),
    .color_in(color_in),
    .flush(flush),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .wr_strb(wr_strb)
  );

  chunk_memory memory_inst (
    .clk_in(clk_in),
    .reset(reset),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .wr_strb(wr_strb),
    .rd_addr_valid(rd_addr_valid),
    .rd_addr_ready(rd_addr_ready),
    .rd_addr(rd_addr),
    .rd_last_in(rd_last_in),
    .chunk_tvalid(chunk_tvalid),
    .chunk_tready(chunk_tready),
    .chunk_tdata(chunk_tdata),
    .chunk_tlast(chunk_tlast)
  );

  // steps only on an accepted read request
  zoom_counter #(
    .SCALE_FACTOR(SCALE_FACTOR)
  ) read_addr_counter (
    .clk_in(clk_in),
    .reset(reset),
    .evt_in(rd_addr_valid && rd_addr_ready),
    .count_out(rd_addr),
    .last_out(rd_last_in)
  );

  unstacker unstacker_inst (
    .clk_in(clk_in),
    .reset(reset),
    .chunk_tvalid(chunk_tvalid),
    .chunk_tready(chunk_tready),
    .chunk_tdata(chunk_tdata),
    .chunk_tlast(chunk_tlast),
    .pixel_tvalid(frame_buff_tvalid),
    .pixel_tready(frame_buff_tready),
    .pixel_tdata(frame_buff_tdata),
    .pixel_tlast(frame_buff_tlast)
  );

endmodule

`default_nettype wire

// ==== rtl/framebuffer_consts.svh ====
`ifndef FRAMEBUFFER_CONSTS_SVH
`define FRAMEBUFFER_CONSTS_SVH

// frame geometry in pixels
`define FB_HRES 32
`define FB_VRES 8

// one chunk is eight pixels, one 128-bit memory word
`define FB_CHUNK_PIXELS 8
`define FB_CHUNK_HRES (`FB_HRES / `FB_CHUNK_PIXELS)
// chunks per frame
`define FB_CHUNK_DEPTH (`FB_CHUNK_HRES * `FB_VRES)

// rgb565 pixels
`define FB_PIXEL_W 16
// linear pixel address, 32 x 8 pixels
`define FB_ADDR_W 8
`define FB_CHUNK_ADDR_W 5

// default row repeat on scanout
`define FB_SCALE 2

`endif

// ==== rtl/framebuffer_pkg.sv ====
`include "framebuffer_consts.svh"

package framebuffer_pkg;

  // one pixel as sent by the rasterizer
  typedef logic [`FB_PIXEL_W-1:0] pixel_t;
  typedef logic [`FB_ADDR_W-1:0] pixel_addr_t;
  typedef logic [`FB_CHUNK_ADDR_W-1:0] chunk_addr_t;

  // lane 0 sits in the lowest bits
  typedef logic [`FB_CHUNK_PIXELS*`FB_PIXEL_W-1:0] chunk_data_t;
  // byte enables, two per pixel lane
  typedef logic [`FB_CHUNK_PIXELS*`FB_PIXEL_W/8-1:0] chunk_strb_t;

  // stacker holds either nothing or one open chunk
  typedef enum logic {
    EMPTY,
    FILLING
  } stack_state_t;

endpackage

// ==== rtl/pixel_stacker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "framebuffer_consts.svh"

module pixel_stacker (
  input wire clk_in,
  input wire reset,
  // single pixels from the rasterizer
  input wire valid_in,
  input wire framebuffer_pkg::pixel_addr_t addr_in,
  input wire framebuffer_pkg::pixel_t color_in,
  input wire flush,
  // strobed chunk writes to memory
  output logic wr_en,
  output framebuffer_pkg::chunk_addr_t wr_addr,
  output framebuffer_pkg::chunk_data_t wr_data,
  output framebuffer_pkg::chunk_strb_t wr_strb
);
  import framebuffer_pkg::*;

  localparam int LANE_W = $clog2(`FB_CHUNK_PIXELS);
  localparam int LAST_LANE = `FB_CHUNK_PIXELS - 1;
  localparam int LANE_BYTES = `FB_PIXEL_W / 8;

  // open chunk
  stack_state_t state;
  chunk_addr_t cur_addr;
  chunk_data_t cur_data;
  chunk_strb_t cur_strb;

  chunk_addr_t in_chunk;
  logic [LANE_W-1:0] in_lane;
  chunk_data_t merge_data;
  chunk_strb_t lane_strb;
  chunk_strb_t merge_strb;
  logic same_chunk;
  logic lane7_held;

  // upper address bits pick the chunk, low bits the lane
  assign in_chunk = addr_in[`FB_ADDR_W-1:LANE_W];
  assign in_lane = addr_in[LANE_W-1:0];
  // an empty stacker takes any chunk
  assign same_chunk = (state == EMPTY) || (in_chunk == cur_addr);
  // only happens when a chunk change lands on lane 7
  assign lane7_held = (state == FILLING) && cur_strb[LANE_BYTES*LAST_LANE];

  always_comb begin
    lane_strb = '0;
    lane_strb[in_lane*LANE_BYTES +: LANE_BYTES] = '1;
    // repeated lane simply overwrites, last color wins
    merge_data = cur_data;
    merge_data[in_lane*`FB_PIXEL_W +: `FB_PIXEL_W] = color_in;
    // strobes are all clear while empty
    merge_strb = cur_strb | lane_strb;
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      state <= EMPTY;
      cur_strb <= '0;
      wr_en <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (valid_in && same_chunk) begin
        cur_addr <= in_chunk;
        cur_data <= merge_data;
        if (in_lane == LANE_W'(LAST_LANE) || lane7_held || flush) begin
          // chunk done, send merged word
          wr_en <= 1'b1;
          wr_addr <= in_chunk;
          wr_data <= merge_data;
          wr_strb <= merge_strb;
          state <= EMPTY;
          cur_strb <= '0;
        end else begin
          state <= FILLING;
          cur_strb <= merge_strb;
        end
      end else if (valid_in) begin
        // chunk change: old one out, new pixel opens the next chunk
        wr_en <= 1'b1;
        wr_addr <= cur_addr;
        wr_data <= cur_data;
        wr_strb <= cur_strb;
        cur_addr <= in_chunk;
        cur_data <= merge_data;
        cur_strb <= lane_strb;
        state <= FILLING;
      end else if (state == FILLING && (flush || lane7_held)) begin
        wr_en <= 1'b1;
        wr_addr <= cur_addr;
        wr_data <= cur_data;
        wr_strb <= cur_strb;
        state <= EMPTY;
        cur_strb <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/unstacker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "framebuffer_consts.svh"

module unstacker (
  input wire clk_in,
  input wire reset,
  // chunks from memory
  input wire chunk_tvalid,
  output logic chunk_tready,
  input wire framebuffer_pkg::chunk_data_t chunk_tdata,
  input wire chunk_tlast,
  // pixel stream out
  output logic pixel_tvalid,
  input wire pixel_tready,
  output framebuffer_pkg::pixel_t pixel_tdata,
  output logic pixel_tlast
);
  import framebuffer_pkg::*;

  localparam int LANE_W = $clog2(`FB_CHUNK_PIXELS);
  localparam int LAST_LANE = `FB_CHUNK_PIXELS - 1;

  chunk_data_t chunk_reg;
  logic chunk_last;
  logic [LANE_W-1:0] lane;
  logic at_last_lane;
  logic beat;

  assign at_last_lane = (lane == LANE_W'(LAST_LANE));
  assign beat = pixel_tvalid && pixel_tready;
  // take a new chunk when empty or as lane 7 leaves
  assign chunk_tready = !pixel_tvalid || (beat && at_last_lane);

  assign pixel_tdata = chunk_reg[lane*`FB_PIXEL_W +: `FB_PIXEL_W];
  assign pixel_tlast = chunk_last && at_last_lane;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      pixel_tvalid <= 1'b0;
      lane <= '0;
      chunk_last <= 1'b0;
    end else if (chunk_tvalid && chunk_tready) begin
      // load, first pixel shows on the next cycle
      chunk_reg <= chunk_tdata;
      chunk_last <= chunk_tlast;
      lane <= '0;
      pixel_tvalid <= 1'b1;
    end else if (beat) begin
      if (at_last_lane) begin
        pixel_tvalid <= 1'b0;
      end else begin
        lane <= lane + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/zoom_counter.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "framebuffer_consts.svh"

module zoom_counter #(
  parameter int SCALE_FACTOR = 1
) (
  input wire clk_in,
  input wire reset,
  input wire evt_in,
  output framebuffer_pkg::chunk_addr_t count_out,
  output logic last_out
);
  import framebuffer_pkg::*;

  localparam int COL_W = $clog2(`FB_CHUNK_HRES);
  localparam int ROW_W = $clog2(`FB_VRES);
  // keep at least one bit when there is no repeat
  localparam int REP_W = (SCALE_FACTOR > 1) ? $clog2(SCALE_FACTOR) : 1;

  logic [COL_W-1:0] col;
  logic [REP_W-1:0] rep;
  logic [ROW_W-1:0] row;
  logic col_end;
  logic rep_end;
  logic row_end;

  assign col_end = (col == COL_W'(`FB_CHUNK_HRES - 1));
  assign rep_end = (rep == REP_W'(SCALE_FACTOR - 1));
  assign row_end = (row == ROW_W'(`FB_VRES - 1));

  // raster order chunk address
  assign count_out = chunk_addr_t'(row * `FB_CHUNK_HRES + col);
  // last chunk of the last repeat of the last row
  assign last_out = col_end && rep_end && row_end;

  // column innermost, then repeat, then row
  always_ff @(posedge clk_in) begin
    if (reset) begin
      col <= '0;
      rep <= '0;
      row <= '0;
    end else if (evt_in) begin
      if (col_end) begin
        col <= '0;
        if (rep_end) begin
          rep <= '0;
          row <= row_end ? '0 : row + 1'b1;
        end else begin
          rep <= rep + 1'b1;
        end
      end else begin
        col <= col + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/framebuffer_tb.sv ====
`timescale 1ns/1ps
`include "framebuffer_consts.svh"

module framebuffer_tb;
  import framebuffer_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_PIXELS = `FB_HRES * `FB_VRES;
  // output beats per zoomed row and per zoomed frame
  localparam int ROW_BEATS = `FB_HRES * `FB_SCALE;
  localparam int FRAME_BEATS = NUM_PIXELS * `FB_SCALE;
  localparam int NUM_FRAMES = 9;
  localparam int NUM_TESTS = 6;
  // 8 clocks per scanned pixel, plus room for the write phases
  localparam int TIMEOUT = (NUM_FRAMES * FRAME_BEATS * 8 + 2000) * CLK_PERIOD;

  logic clk_in;
  logic reset;
  logic valid_in;
  pixel_addr_t addr_in;
  pixel_t color_in;
  logic flush;
  logic scan_enable;
  logic frame_buff_tvalid;
  logic frame_buff_tready;
  pixel_t frame_buff_tdata;
  logic frame_buff_tlast;

  // shadow frame, linear pixel address
  pixel_t shadow [NUM_PIXELS];
  integer seed = 56;
  int errors = 0;
  int checks = 0;
  int test_errors = 0;
  // scanout position, kept by the checker
  int beat_idx = 0;
  int frames_done = 0;
  int tlast_seen = 0;

  framebuffer #(
    .SCALE_FACTOR(`FB_SCALE)
  ) uut (
    .clk_in(clk_in),
    .reset(reset),
    .valid_in(valid_in),
    .addr_in(addr_in),
    .color_in(color_in),
    .flush(flush),
    .scan_enable(scan_enable),
    .frame_buff_tvalid(frame_buff_tvalid),
    .frame_buff_tready(frame_buff_tready),
    .frame_buff_tdata(frame_buff_tdata),
    .frame_buff_tlast(frame_buff_tlast)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // starts on a falling edge, ends on the next one
  task automatic send_pixel(input int addr, input pixel_t color);
    valid_in = 1'b1;
    addr_in = pixel_addr_t'(addr);
    color_in = color;
    shadow[addr] = color;
    @(negedge clk_in);
    valid_in = 1'b0;
  endtask

  // one extra cycle so the flushed chunk lands in memory
  task automatic flush_stacker();
    flush = 1'b1;
    @(negedge clk_in);
    flush = 1'b0;
    @(negedge clk_in);
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frames_done + n;
    while (frames_done < target) @(negedge clk_in);
  endtask

  // prefetched chunks leave, then the output stays idle
  task automatic drain_scanout();
    int idle;
    idle = 0;
    while (idle < 3) begin
      @(negedge clk_in);
      idle = frame_buff_tvalid ? 0 : idle + 1;
    end
  endtask

  // scanout checker, zoomed raster order
  always @(posedge clk_in) begin
    int row;
    int col;
    if (!reset && frame_buff_tvalid && frame_buff_tready) begin
      row = beat_idx / ROW_BEATS;
      col = beat_idx % `FB_HRES;
      check_value(frame_buff_tdata, shadow[row * `FB_HRES + col], "scanout pixel");
      check_value(frame_buff_tlast, beat_idx == FRAME_BEATS - 1, "frame_buff_tlast");
      if (frame_buff_tlast) tlast_seen++;
      if (beat_idx == FRAME_BEATS - 1) begin
        beat_idx = 0;
        frames_done++;
      end else begin
        beat_idx++;
      end
    end
  end

  // watchdog
  initial begin
    #(TIMEOUT);
    $display("timeout: scanout stalled after %0d frames", frames_done);
    $display("Checks failed");
    $finish;
  end

  initial begin
    int addr;
    int last_addr;
    int gap;
    int burst_len;
    int out_row;
    int start_frames;
    int start_tlast;
    reset = 1'b1;
    valid_in = 1'b0;
    addr_in = '0;
    color_in = '0;
    flush = 1'b0;
    scan_enable = 1'b0;
    frame_buff_tready = 1'b1;
    repeat (10) @(negedge clk_in);
    reset = 1'b0;

    // idle output with scan off
    repeat (20) begin
      @(negedge clk_in);
      check_value(frame_buff_tvalid, 1'b0, "tvalid before scan_enable");
    end
    report_test("reset");

    // whole frame in address order
    for (int a = 0; a < NUM_PIXELS; a++) send_pixel(a, pixel_t'($random(seed)));
    flush_stacker();
    scan_enable = 1'b1;
    wait_frames(1);
    report_test("full_frame");

    // scattered writes with scan stopped and drained
    scan_enable = 1'b0;
    drain_scanout();
    last_addr = 0;
    repeat (40) begin
      // about one in five hits the previous address again
      addr = ({$random(seed)} % 5 == 0) ? last_addr : {$random(seed)} % NUM_PIXELS;
      last_addr = addr;
      send_pixel(addr, pixel_t'($random(seed)));
      gap = {$random(seed)} % 3;
      repeat (gap) @(negedge clk_in);
    end
    flush_stacker();
    scan_enable = 1'b1;
    wait_frames(2);
    report_test("partial_chunks");

    // tlast once per frame, position checked per beat
    start_tlast = tlast_seen;
    wait_frames(1);
    check_value(tlast_seen - start_tlast, 1, "tlast count per frame");
    report_test("frame_boundary");

    // ready low about 40 percent of cycles
    start_frames = frames_done;
    while (frames_done < start_frames + 2) begin
      @(negedge clk_in);
      frame_buff_tready = ({$random(seed)} % 10) >= 4;
    end
    frame_buff_tready = 1'b1;
    report_test("back_pressure");

    // bursts into rows already scanned, during the first frame only
    start_frames = frames_done;
    while (frames_done < start_frames + 2) begin
      @(negedge clk_in);
      out_row = beat_idx / ROW_BEATS;
      if (frames_done == start_frames && out_row >= 1 && out_row <= `FB_VRES - 2 &&
          {$random(seed)} % 8 == 0) begin
        burst_len = 1 + {$random(seed)} % 5;
        repeat (burst_len) begin
          addr = {$random(seed)} % (out_row * `FB_HRES);
          send_pixel(addr, pixel_t'($random(seed)));
        end
        flush_stacker();
      end
    end
    report_test("writes_during_scan");

    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
